// File: common/agc_bus_pkg.sv
`default_nettype none

// Wishbone types shared by the loop master port and the host target port
package agc_bus_pkg;

    // Byte address and data word
    typedef logic [7:0]  wb_adr_t;
    typedef logic [31:0] wb_dat_t;

    ////////////////////////////////////////
    // Master to target lines
    ////////////////////////////////////////
    typedef struct packed {
        logic    cyc;  // Bus cycle in progress
        logic    stb;  // Transfer request
        logic    we;   // Write when high
        wb_adr_t adr;
        wb_dat_t dat;  // Write data
    } wb_m2s_t;

    ////////////////////////////////////////
    // Target to master lines
    ////////////////////////////////////////
    typedef struct packed {
        logic    ack;  // Transfer done, one cycle
        wb_dat_t dat;  // Read data, valid with ack
    } wb_s2m_t;

endpackage

`default_nettype wire

// File: common/agc_loop_pkg.sv
`default_nettype none

// AGC register map, command words and the loop's own types
package agc_loop_pkg;

    import agc_bus_pkg::*;

    // Values the loop writes to the AGC module
    typedef logic [16:0] agc_scale_t;
    typedef logic [15:0] agc_offset_t;

    // Info word storage
    localparam int AGC_INFO_WORDS = 6;
    typedef logic [2:0] agc_info_idx_t;
    // 0 status, 1 sum of squares, 2 count above, 3 count below,
    // 4 current scale, 5 current offset
    typedef wb_dat_t [AGC_INFO_WORDS-1:0] agc_info_t;

    ////////////////////////////////////////
    // AGC module register map
    ////////////////////////////////////////
    localparam wb_adr_t AGC_CTRL_ADR   = 8'h00;  // Control writes, status reads
    localparam wb_adr_t AGC_SCALE_ADR  = 8'h10;
    localparam wb_adr_t AGC_OFFSET_ADR = 8'h14;

    // Command words for the control register
    localparam wb_dat_t CMD_RESET = 32'h0000_0004;  // Clear statistics
    localparam wb_dat_t CMD_START = 32'h0000_0001;  // Begin a sample period
    localparam wb_dat_t CMD_LOAD  = 32'h0000_0300;
    localparam wb_dat_t CMD_APPLY = 32'h0000_0400;

    localparam int STATUS_DONE_BIT = 1;  // Sample period finished

    // Gain limits and boot values
    localparam agc_scale_t  START_SCALE  = 17'd1800;
    localparam agc_offset_t START_OFFSET = 16'd0;
    localparam agc_scale_t  SCALE_MIN    = 17'd300;
    localparam agc_scale_t  SCALE_MAX    = 17'h1FBD0;

    // Loop sequence, one step per AGC command group
    typedef enum logic [3:0] {
        BOOT,
        RESETTING,
        POLLING,
        WAITING,
        READING,
        CALCULATING,
        WRITING,
        LOADING,
        APPLYING
    } loop_state_e;

    // Scale goes out zero extended
    function automatic wb_dat_t scale_to_dat(input agc_scale_t scale);
        return {15'd0, scale};
    endfunction

    // Offset goes out sign extended
    function automatic wb_dat_t offset_to_dat(input agc_offset_t offset);
        return {{16{offset[15]}}, offset};
    endfunction

endpackage

`default_nettype wire

// File: agc_loop/agc_loop_seq.sv
`timescale 1ns/1ns
`default_nettype none

module agc_loop_seq #(
    parameter int BOOT_DELAY_CYCLES = 31
) (
    input  wire                       wb_clk_i,
    input  wire                       rst_n_i,
    output agc_bus_pkg::wb_m2s_t      agc_m_o,
    input  agc_bus_pkg::wb_s2m_t      agc_s_i,
    input  agc_loop_pkg::agc_scale_t  scale_i,    // From the gain calculator
    input  agc_loop_pkg::agc_offset_t offset_i,
    output logic                      calc_en_o,
    output agc_loop_pkg::agc_info_t   info_o
);

    import agc_bus_pkg::*;
    import agc_loop_pkg::*;

    localparam int BOOT_CNT_W = (BOOT_DELAY_CYCLES > 0) ? $clog2(BOOT_DELAY_CYCLES + 1) : 1;

    // Progress of one bus transfer within a loop step
    typedef enum logic [1:0] {
        COMM_SEND,
        COMM_WAIT,
        COMM_PROC
    } comm_state_e;

    loop_state_e            state_q;
    comm_state_e            sub_q;
    agc_info_idx_t          info_idx_q;  // Word being read, or 0 scale / 1 offset when writing
    logic [BOOT_CNT_W-1:0]  boot_cnt_q;
    agc_info_t              info_q;
    wb_m2s_t                bus_q;
    wb_m2s_t                req;         // Transfer for the current step
    wb_dat_t                resp_q;      // Read data taken at ack

    function automatic wb_m2s_t wb_req(input logic we, input wb_adr_t adr, input wb_dat_t dat);
        wb_m2s_t r;
        r.cyc = 1'b1;
        r.stb = 1'b1;
        r.we  = we;
        r.adr = adr;
        r.dat = dat;
        return r;
    endfunction

    ////////////////////////////////////////
    // Request for each step
    ////////////////////////////////////////
    always_comb begin
        case (state_q)
            RESETTING: req = wb_req(1'b1, AGC_CTRL_ADR, CMD_RESET);
            POLLING:   req = wb_req(1'b1, AGC_CTRL_ADR, CMD_START);
            WAITING:   req = wb_req(1'b0, AGC_CTRL_ADR, '0);        // Status read
            READING:   req = wb_req(1'b0, {3'b000, info_idx_q, 2'b00}, '0);
            WRITING: begin
                if (info_idx_q == 3'd0) begin
                    req = wb_req(1'b1, AGC_SCALE_ADR, scale_to_dat(scale_i));
                end else begin
                    req = wb_req(1'b1, AGC_OFFSET_ADR, offset_to_dat(offset_i));
                end
            end
            LOADING:   req = wb_req(1'b1, AGC_CTRL_ADR, CMD_LOAD);
            APPLYING:  req = wb_req(1'b1, AGC_CTRL_ADR, CMD_APPLY);
            default:   req = '0;  // No transfer in BOOT or CALCULATING
        endcase
    end

    ////////////////////////////////////////
    // Loop sequencer
    ////////////////////////////////////////
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= BOOT;
            sub_q      <= COMM_SEND;
            info_idx_q <= '0;
            boot_cnt_q <= BOOT_CNT_W'(BOOT_DELAY_CYCLES);
            bus_q      <= '0;
            info_q     <= '0;
            info_q[4]  <= scale_to_dat(START_SCALE);
            info_q[5]  <= offset_to_dat(START_OFFSET);
        end else begin
            case (state_q)
                BOOT: begin
                    if (boot_cnt_q != '0) begin
                        boot_cnt_q <= boot_cnt_q - 1'b1;
                    end else begin
                        state_q    <= WRITING;  // Push the start values first
                        info_idx_q <= '0;
                    end
                end
                CALCULATING: begin
                    // Calculator latches on this edge
                    state_q    <= WRITING;
                    info_idx_q <= '0;
                end
                default: begin
                    case (sub_q)
                        COMM_SEND: begin
                            bus_q <= req;
                            sub_q <= COMM_WAIT;
                        end
                        COMM_WAIT: begin
                            if (agc_s_i.ack) begin
                                bus_q.cyc <= 1'b0;
                                bus_q.stb <= 1'b0;
                                bus_q.we  <= 1'b0;
                                sub_q     <= COMM_PROC;
                                if (state_q == APPLYING) begin
                                    // Values now live in the AGC module
                                    info_q[4] <= scale_to_dat(scale_i);
                                    info_q[5] <= offset_to_dat(offset_i);
                                end
                            end
                        end
                        default: begin
                            sub_q <= COMM_SEND;
                            case (state_q)
                                RESETTING: state_q <= POLLING;
                                POLLING:   state_q <= WAITING;
                                WAITING: begin
                                    if (resp_q[STATUS_DONE_BIT]) begin
                                        state_q    <= READING;
                                        info_idx_q <= '0;
                                    end
                                end
                                READING: begin
                                    info_q[info_idx_q] <= resp_q;
                                    if (info_idx_q == agc_info_idx_t'(AGC_INFO_WORDS - 1)) begin
                                        state_q    <= CALCULATING;
                                        info_idx_q <= '0;
                                    end else begin
                                        info_idx_q <= info_idx_q + 1'b1;
                                    end
                                end
                                WRITING: begin
                                    if (info_idx_q == 3'd0) begin
                                        info_idx_q <= 3'd1;  // Offset next
                                    end else begin
                                        state_q    <= LOADING;
                                        info_idx_q <= '0;
                                    end
                                end
                                LOADING:  state_q <= APPLYING;
                                default:  state_q <= RESETTING;  // After apply
                            endcase
                        end
                    endcase
                end
            endcase
        end
    end

    // Read data capture
    always_ff @(posedge wb_clk_i) begin
        if (sub_q == COMM_WAIT && agc_s_i.ack) begin
            resp_q <= agc_s_i.dat;
        end
    end

    assign agc_m_o   = bus_q;
    assign calc_en_o = (state_q == CALCULATING);  // One cycle per loop
    assign info_o    = info_q;

endmodule

`default_nettype wire

// File: agc_loop/agc_gain_calc.sv
`timescale 1ns/1ns
`default_nettype none

module agc_gain_calc #(
    parameter int AGC_TIMESCALE_REDUCTION_BITS = 4,
    parameter int TARGET_RMS_SQUARED           = 16,
    parameter int RMS_SQUARE_SCALE_ERR         = 0,
    parameter int OFFSET_ERR                   = 5,
    parameter int SCALE_DELTA                  = 30,
    parameter int OFFSET_DELTA                 = 25
) (
    input  wire                       wb_clk_i,
    input  wire                       rst_n_i,
    input  wire                       calc_en_i,  // Latch new values
    input  agc_loop_pkg::agc_info_t   info_i,
    output agc_loop_pkg::agc_scale_t  scale_o,
    output agc_loop_pkg::agc_offset_t offset_o
);

    import agc_bus_pkg::*;
    import agc_loop_pkg::*;

    // Sum of squares down to a per-sample mean
    localparam int          MS_SHIFT    = 17 - AGC_TIMESCALE_REDUCTION_BITS;
    localparam wb_dat_t     MS_HIGH     = wb_dat_t'(TARGET_RMS_SQUARED + RMS_SQUARE_SCALE_ERR);
    localparam wb_dat_t     MS_LOW      = wb_dat_t'(TARGET_RMS_SQUARED - RMS_SQUARE_SCALE_ERR);
    localparam wb_dat_t     OFS_MARGIN  = wb_dat_t'(OFFSET_ERR);
    localparam agc_scale_t  SCALE_STEP  = agc_scale_t'(SCALE_DELTA);
    localparam agc_offset_t OFFSET_STEP = agc_offset_t'(OFFSET_DELTA);

    wb_dat_t     mean_sq;
    agc_scale_t  cur_scale;   // Scale the AGC module runs with
    agc_offset_t cur_offset;
    agc_scale_t  scale_d;
    agc_offset_t offset_d;
    agc_scale_t  scale_q;
    agc_offset_t offset_q;

    assign mean_sq    = info_i[1] >> MS_SHIFT;
    assign cur_scale  = info_i[4][16:0];
    assign cur_offset = info_i[5][15:0];

    ////////////////////////////////////////
    // Fixed step up or down
    ////////////////////////////////////////
    always_comb begin
        scale_d = scale_q;
        if (mean_sq > MS_HIGH) begin  // Too loud
            scale_d = (cur_scale > SCALE_MIN) ? cur_scale - SCALE_STEP : cur_scale;
        end else if (mean_sq < MS_LOW) begin
            scale_d = (cur_scale < SCALE_MAX) ? cur_scale + SCALE_STEP : cur_scale;
        end
    end

    // Balance counts above and below
    always_comb begin
        offset_d = offset_q;
        if (info_i[2] > info_i[3] + OFS_MARGIN) begin
            offset_d = cur_offset - OFFSET_STEP;
        end else if (info_i[3] > info_i[2] + OFS_MARGIN) begin
            offset_d = cur_offset + OFFSET_STEP;
        end
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            scale_q  <= START_SCALE;
            offset_q <= START_OFFSET;
        end else if (calc_en_i) begin
            scale_q  <= scale_d;
            offset_q <= offset_d;
        end
    end

    assign scale_o  = scale_q;
    assign offset_o = offset_q;

endmodule

`default_nettype wire

// File: rtl/agc_info_readback.sv
`timescale 1ns/1ns
`default_nettype none

module agc_info_readback #(
    parameter int SCALE_DELTA  = 30,
    parameter int OFFSET_DELTA = 25
) (
    input  wire                     wb_clk_i,
    input  wire                     rst_n_i,
    input  agc_bus_pkg::wb_m2s_t    host_m_i,
    output agc_bus_pkg::wb_s2m_t    host_s_o,
    input  agc_loop_pkg::agc_info_t info_i    // Words from the loop sequencer
);

    import agc_bus_pkg::*;
    import agc_loop_pkg::*;

    // Host transfer handling
    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE,
        ACK
    } rb_state_e;

    rb_state_e  state_q;
    logic [3:0] word_sel;  // Word index from the byte address
    wb_dat_t    rd_word;
    wb_dat_t    resp_q;

    assign word_sel = host_m_i.adr[5:2];

    ////////////////////////////////////////
    // Target FSM
    ////////////////////////////////////////
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (host_m_i.cyc && host_m_i.stb) begin
                        state_q <= host_m_i.we ? WRITE : READ;
                    end
                end
                READ:    state_q <= ACK;
                WRITE:   state_q <= ACK;  // Nothing writable yet
                default: state_q <= IDLE;
            endcase
        end
    end

    // Bit 6 picks loop step sizes over AGC info words
    always_comb begin
        rd_word = '0;
        if (host_m_i.adr[6]) begin
            case (word_sel)
                4'd0:    rd_word = scale_to_dat(agc_scale_t'(SCALE_DELTA));
                4'd1:    rd_word = offset_to_dat(agc_offset_t'(OFFSET_DELTA));
                default: rd_word = '0;
            endcase
        end else if (word_sel < 4'(AGC_INFO_WORDS)) begin
            rd_word = info_i[word_sel];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (state_q == READ) begin
            resp_q <= rd_word;
        end
    end

    assign host_s_o.ack = (state_q == ACK);  // Single cycle
    assign host_s_o.dat = resp_q;

endmodule

`default_nettype wire

// File: rtl/agc_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module agc_ctrl_top #(
    parameter int AGC_TIMESCALE_REDUCTION_BITS = 4,
    parameter int TARGET_RMS_SQUARED           = 16,
    parameter int RMS_SQUARE_SCALE_ERR         = 0,
    parameter int OFFSET_ERR                   = 5,
    parameter int SCALE_DELTA                  = 30,
    parameter int OFFSET_DELTA                 = 25,
    parameter int BOOT_DELAY_CYCLES            = 31
) (
    input  wire                    wb_clk_i,
    input  wire                    rst_n_i,
    output agc_bus_pkg::wb_m2s_t   agc_m_o,   // To the AGC module
    input  agc_bus_pkg::wb_s2m_t   agc_s_i,
    input  agc_bus_pkg::wb_m2s_t   host_m_i,  // From the host
    output agc_bus_pkg::wb_s2m_t   host_s_o
);

    import agc_loop_pkg::*;

    logic        calc_en;
    agc_info_t   info;    // Last words read from the AGC module
    agc_scale_t  scale;   // Recalculated scale
    agc_offset_t offset;  // Recalculated offset

    // Command and read sequence towards the AGC module
    agc_loop_seq #(
        .BOOT_DELAY_CYCLES (BOOT_DELAY_CYCLES)
    ) i_loop_seq (
        .wb_clk_i  (wb_clk_i),
        .rst_n_i   (rst_n_i),
        .agc_m_o   (agc_m_o),
        .agc_s_i   (agc_s_i),
        .scale_i   (scale),
        .offset_i  (offset),
        .calc_en_o (calc_en),
        .info_o    (info)
    );

    agc_gain_calc #(
        .AGC_TIMESCALE_REDUCTION_BITS (AGC_TIMESCALE_REDUCTION_BITS),
        .TARGET_RMS_SQUARED           (TARGET_RMS_SQUARED),
        .RMS_SQUARE_SCALE_ERR         (RMS_SQUARE_SCALE_ERR),
        .OFFSET_ERR                   (OFFSET_ERR),
        .SCALE_DELTA                  (SCALE_DELTA),
        .OFFSET_DELTA                 (OFFSET_DELTA)
    ) i_gain_calc (
        .wb_clk_i  (wb_clk_i),
        .rst_n_i   (rst_n_i),
        .calc_en_i (calc_en),
        .info_i    (info),
        .scale_o   (scale),
        .offset_o  (offset)
    );

    // Host side readback
    agc_info_readback #(
        .SCALE_DELTA  (SCALE_DELTA),
        .OFFSET_DELTA (OFFSET_DELTA)
    ) i_info_readback (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .host_m_i (host_m_i),
        .host_s_o (host_s_o),
        .info_i   (info)
    );

endmodule

`default_nettype wire

// File: tests/agc_ctrl_properties.sv
`timescale 1ns/1ns
`default_nettype none

module agc_ctrl_properties (
    input wire                  wb_clk_i,
    input wire                  rst_n_i,
    input agc_bus_pkg::wb_m2s_t bus_m_i,  // Master side of the watched bus
    input agc_bus_pkg::wb_s2m_t bus_s_i   // Target side
);

    int fail_cnt = 0;  // Failed assertions so far

    ////////////////////////////////////////
    // Wishbone handshake rules
    ////////////////////////////////////////

    // Request held until the target answers
    property req_stable_p;
        @(posedge wb_clk_i) disable iff (!rst_n_i)
            (bus_m_i.stb && !bus_s_i.ack) |=> $stable({bus_m_i.adr, bus_m_i.we, bus_m_i.dat});
    endproperty

    property cyc_drop_p;
        @(posedge wb_clk_i) disable iff (!rst_n_i)
            bus_s_i.ack |=> !bus_m_i.cyc;
    endproperty

    // Ack is a single pulse
    property ack_pulse_p;
        @(posedge wb_clk_i) disable iff (!rst_n_i)
            bus_s_i.ack |=> !bus_s_i.ack;
    endproperty

    req_stable_a: assert property (req_stable_p) else begin
        fail_cnt++;
        $error("Request changed while waiting for ack");
    end
    cyc_drop_a: assert property (cyc_drop_p) else begin
        fail_cnt++;
        $error("cyc still high in the cycle after ack");
    end
    ack_pulse_a: assert property (ack_pulse_p) else begin
        fail_cnt++;
        $error("ack held for more than one cycle");
    end

endmodule

`default_nettype wire

// File: tests/tb_agc_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_agc_ctrl;

    import agc_bus_pkg::*;
    import agc_loop_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int LOOPS       = 40;
    localparam int SLOW_LOOPS  = 10;  // Last loops with long ack delays
    localparam int REQ_LIMIT   = 200;
    localparam int ACK_LIMIT   = 20;
    localparam int POLL_LIMIT  = 10;
    localparam int MS_SHIFT    = 13;  // 17 minus the timescale reduction bits
    localparam int MS_TARGET   = 16;
    localparam int MS_ERR      = 0;
    localparam int OFS_ERR     = 5;
    localparam int SCALE_STEP  = 30;
    localparam int OFFSET_STEP = 25;
    localparam wb_dat_t DONE_MASK = 32'h1 << STATUS_DONE_BIT;

    logic    wb_clk_i = 1'b0;
    logic    rst_n_i;
    wb_m2s_t agc_m;
    wb_s2m_t agc_s;
    wb_m2s_t host_m;
    wb_s2m_t host_s;

    integer  seed = 13;
    int      err_cnt = 0;
    int      chk_cnt = 0;
    logic    slow_acks;

    // AGC module model state
    wb_dat_t status_word, sum_sq, cnt_above, cnt_below;
    wb_dat_t mdl_scale, mdl_offset;      // Active in the AGC module
    wb_dat_t pend_scale, pend_offset;    // Written but not yet loaded
    wb_dat_t load_scale, load_offset;
    int      polls_left;

    wb_dat_t     info_rd  [0:5];  // Words read in the current loop
    wb_dat_t     exp_info [0:5];  // Expected host readback
    agc_scale_t  ref_scale;
    agc_offset_t ref_offset;

    agc_ctrl_top #(
        .AGC_TIMESCALE_REDUCTION_BITS (17 - MS_SHIFT),
        .TARGET_RMS_SQUARED           (MS_TARGET),
        .RMS_SQUARE_SCALE_ERR         (MS_ERR),
        .OFFSET_ERR                   (OFS_ERR),
        .SCALE_DELTA                  (SCALE_STEP),
        .OFFSET_DELTA                 (OFFSET_STEP),
        .BOOT_DELAY_CYCLES            (31)
    ) i_dut (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .agc_m_o  (agc_m),
        .agc_s_i  (agc_s),
        .host_m_i (host_m),
        .host_s_o (host_s)
    );

    bind agc_loop_seq agc_ctrl_properties i_master_props (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .bus_m_i  (agc_m_o),
        .bus_s_i  (agc_s_i)
    );

    bind agc_info_readback agc_ctrl_properties i_host_props (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .bus_m_i  (host_m_i),
        .bus_s_i  (host_s_o)
    );

    always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7FFF_FFFF;
        return lo + (r % (hi - lo + 1));
    endfunction

    function automatic wb_dat_t scale_word(input agc_scale_t s);
        return {15'd0, s};  // Zero extended on the bus
    endfunction

    function automatic wb_dat_t offset_word(input agc_offset_t o);
        return {{16{o[15]}}, o};
    endfunction

    task automatic next_cycle();
        @(posedge wb_clk_i);
        #DRIVE_DELAY;
    endtask

    task automatic finish_run();
        int prop_fails;
        prop_fails = i_dut.i_loop_seq.i_master_props.fail_cnt
                   + i_dut.i_info_readback.i_host_props.fail_cnt;
        err_cnt += prop_fails;
        $display("Checks: %0d, errors: %0d, of them assertion failures: %0d",
                 chk_cnt, err_cnt, prop_fails);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(input string what);
        err_cnt++;
        $display("TIMEOUT at %0t ns: %s", $time, what);
        finish_run();
    endtask

    task automatic check_val(input string name, input wb_dat_t got, input wb_dat_t exp);
        chk_cnt++;
        assert (got === exp) else begin
            err_cnt++;
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // Host side
    ////////////////////////////////////////
    function automatic wb_dat_t readback_exp(input wb_adr_t adr);
        int idx;
        idx = int'(adr[5:2]);
        if (adr[6]) begin
            if (idx == 0) return wb_dat_t'(SCALE_STEP);
            if (idx == 1) return wb_dat_t'(OFFSET_STEP);
            return '0;
        end
        return (idx < 6) ? exp_info[idx] : '0;
    endfunction

    task automatic host_access(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                               output wb_dat_t rdat);
        int n;
        host_m.cyc = 1'b1;
        host_m.stb = 1'b1;
        host_m.we  = we;
        host_m.adr = adr;
        host_m.dat = wdat;
        n = 0;
        do begin
            next_cycle();
            n++;
        end while (!host_s.ack && n < ACK_LIMIT);
        if (!host_s.ack) stop_on_timeout("host transfer got no ack");
        rdat = host_s.dat;
        next_cycle();  // Target closes the ack cycle
        host_m = '0;
        repeat (3) begin
            chk_cnt++;
            assert (!host_s.ack) else begin
                err_cnt++;
                $display("Host transfer at address %h got a second ack", adr);
            end
            next_cycle();
        end
    endtask

    // Optional ignored write followed by a read of the same address
    task automatic host_check(input wb_adr_t adr);
        wb_dat_t rdat;
        if (rand_range(0, 3) == 0) begin
            host_access(1'b1, adr, wb_dat_t'($random(seed)), rdat);
        end
        host_access(1'b0, adr, '0, rdat);
        check_val($sformatf("host_s_o.dat at %h", adr), rdat, readback_exp(adr));
    endtask

    ////////////////////////////////////////
    // AGC module model
    ////////////////////////////////////////
    task automatic agc_read(input wb_adr_t adr, output wb_dat_t rdat);
        case (adr)
            AGC_CTRL_ADR: begin
                if (polls_left > 0) begin
                    polls_left--;
                    rdat = status_word & ~DONE_MASK;
                end else begin
                    rdat = status_word | DONE_MASK;
                end
            end
            8'h04:          rdat = sum_sq;
            8'h08:          rdat = cnt_above;
            8'h0C:          rdat = cnt_below;
            AGC_SCALE_ADR:  rdat = mdl_scale;
            AGC_OFFSET_ADR: rdat = mdl_offset;
            default:        rdat = '0;
        endcase
    endtask

    task automatic agc_write(input wb_adr_t adr, input wb_dat_t dat);
        if (adr == AGC_SCALE_ADR) pend_scale = dat;
        if (adr == AGC_OFFSET_ADR) pend_offset = dat;
        if (adr == AGC_CTRL_ADR && dat == CMD_LOAD) begin
            load_scale  = pend_scale;
            load_offset = pend_offset;
        end
        if (adr == AGC_CTRL_ADR && dat == CMD_APPLY) begin
            mdl_scale  = load_scale;
            mdl_offset = load_offset;
        end
    endtask

    // One transfer with a random ack delay and host traffic while it stalls
    task automatic serve_agc(output wb_m2s_t req, output wb_dat_t rdat);
        int n;
        n = 0;
        while (!(agc_m.cyc && agc_m.stb) && n < REQ_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!(agc_m.cyc && agc_m.stb)) stop_on_timeout("no request from the loop sequencer");
        req = agc_m;
        if (rand_range(0, 3) == 0) host_check(wb_adr_t'(rand_range(0, 255)) & 8'h7C);
        repeat (slow_acks ? 10 : rand_range(1, 4)) next_cycle();
        rdat = '0;
        if (!req.we) agc_read(req.adr, rdat);
        agc_s.ack = 1'b1;
        agc_s.dat = rdat;
        next_cycle();
        agc_s = '0;
        if (req.we) agc_write(req.adr, req.dat);
    endtask

    task automatic expect_write(input wb_adr_t adr, input wb_dat_t dat, input string what);
        wb_m2s_t req;
        wb_dat_t rdat;
        serve_agc(req, rdat);
        check_val({what, ": agc_m_o.we"}, wb_dat_t'(req.we), 32'd1);
        check_val({what, ": agc_m_o.adr"}, wb_dat_t'(req.adr), wb_dat_t'(adr));
        check_val({what, ": agc_m_o.dat"}, req.dat, dat);
    endtask

    task automatic expect_read(input wb_adr_t adr, input string what, output wb_dat_t rdat);
        wb_m2s_t req;
        serve_agc(req, rdat);
        check_val({what, ": agc_m_o.we"}, wb_dat_t'(req.we), 32'd0);
        check_val({what, ": agc_m_o.adr"}, wb_dat_t'(req.adr), wb_dat_t'(adr));
    endtask

    // New statistics for one sample period
    task automatic new_period(input int loop);
        int dir;
        int ms;
        dir = rand_range(0, 2);  // Louder, quieter or on target
        // Some loops push the scale to a cutoff
        case (loop)
            6: begin
                mdl_scale = scale_word(SCALE_MIN);
                dir       = 0;
            end
            7: begin
                mdl_scale = scale_word(SCALE_MIN + 17'd10);
                dir       = 0;
            end
            16: begin
                mdl_scale = scale_word(SCALE_MAX);
                dir       = 1;
            end
            17: begin
                mdl_scale = scale_word(SCALE_MAX - 17'd10);
                dir       = 1;
            end
            default: ;
        endcase
        if (dir == 0) ms = rand_range(MS_TARGET + MS_ERR + 1, 60);
        else if (dir == 1) ms = rand_range(0, MS_TARGET - MS_ERR - 1);
        else ms = MS_TARGET;
        sum_sq      = wb_dat_t'(ms << MS_SHIFT) | wb_dat_t'(rand_range(0, (1 << MS_SHIFT) - 1));
        cnt_above   = wb_dat_t'(rand_range(0, 40));
        cnt_below   = wb_dat_t'(rand_range(0, 40));
        status_word = wb_dat_t'($random(seed));
        polls_left  = rand_range(0, 4);
    endtask

    // Reference gain step from the words just read
    task automatic calc_reference();
        int mean_sq;
        int cur;
        int above;
        int below;
        mean_sq = int'(info_rd[1] >> MS_SHIFT);
        cur     = int'(info_rd[4][16:0]);
        above   = int'(info_rd[2]);
        below   = int'(info_rd[3]);
        if (mean_sq > MS_TARGET + MS_ERR) begin
            ref_scale = (cur > int'(SCALE_MIN)) ? agc_scale_t'(cur - SCALE_STEP)
                                                : agc_scale_t'(cur);
        end else if (mean_sq < MS_TARGET - MS_ERR) begin
            ref_scale = (cur < int'(SCALE_MAX)) ? agc_scale_t'(cur + SCALE_STEP)
                                                : agc_scale_t'(cur);
        end
        if (above > below + OFS_ERR) begin
            ref_offset = info_rd[5][15:0] - agc_offset_t'(OFFSET_STEP);
        end else if (below > above + OFS_ERR) begin
            ref_offset = info_rd[5][15:0] + agc_offset_t'(OFFSET_STEP);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin : main
        wb_dat_t rd;
        int      polls;
        agc_s      = '0;
        host_m     = '0;
        rst_n_i    = 1'b0;
        slow_acks  = 1'b0;
        polls_left = 0;
        {status_word, sum_sq, cnt_above, cnt_below} = '0;
        {mdl_scale, mdl_offset, pend_scale, pend_offset, load_scale, load_offset} = '0;
        exp_info   = '{default: '0};
        exp_info[4] = scale_word(START_SCALE);
        exp_info[5] = offset_word(START_OFFSET);
        ref_scale  = START_SCALE;
        ref_offset = START_OFFSET;
        repeat (5) @(posedge wb_clk_i);
        #DRIVE_DELAY;
        rst_n_i = 1'b1;

        // Start values go out right after boot
        expect_write(AGC_SCALE_ADR, scale_word(START_SCALE), "boot scale");
        expect_write(AGC_OFFSET_ADR, offset_word(START_OFFSET), "boot offset");
        expect_write(AGC_CTRL_ADR, CMD_LOAD, "boot load");
        expect_write(AGC_CTRL_ADR, CMD_APPLY, "boot apply");

        for (int loop = 0; loop < LOOPS; loop++) begin
            slow_acks = (loop >= LOOPS - SLOW_LOOPS);
            expect_write(AGC_CTRL_ADR, CMD_RESET, "reset command");
            expect_write(AGC_CTRL_ADR, CMD_START, "start command");
            new_period(loop);
            polls = 0;
            do begin
                expect_read(AGC_CTRL_ADR, "status poll", rd);
                polls++;
            end while (!rd[STATUS_DONE_BIT] && polls < POLL_LIMIT);
            if (!rd[STATUS_DONE_BIT]) stop_on_timeout("status never showed done");
            for (int i = 0; i < AGC_INFO_WORDS; i++) begin
                expect_read(wb_adr_t'(4 * i), $sformatf("info word %0d", i), info_rd[i]);
                exp_info[i] = info_rd[i];
            end
            calc_reference();
            expect_write(AGC_SCALE_ADR, scale_word(ref_scale), "scale write");
            expect_write(AGC_OFFSET_ADR, offset_word(ref_offset), "offset write");
            expect_write(AGC_CTRL_ADR, CMD_LOAD, "load command");
            expect_write(AGC_CTRL_ADR, CMD_APPLY, "apply command");
            exp_info[4] = scale_word(ref_scale);  // Applied values
            exp_info[5] = offset_word(ref_offset);
        end

        // Loop now stalls on the reset command while every readback address is swept
        for (int a = 0; a < 32; a++) begin
            host_check(wb_adr_t'(a << 2));
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: files.f
common/agc_bus_pkg.sv
common/agc_loop_pkg.sv
agc_loop/agc_loop_seq.sv
agc_loop/agc_gain_calc.sv
rtl/agc_info_readback.sv
rtl/agc_ctrl_top.sv
tests/agc_ctrl_properties.sv
tests/tb_agc_ctrl.sv

// File: Makefile
# Verilator simulation of the AGC control loop

VERILATOR ?= verilator
TOP       ?= tb_agc_ctrl
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^NO ERRORS$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
